/* list.f */
+incdir+source
source/ldst_pkg.sv
source/mem_pkg.sv
source/lsu_cmd_port.sv
source/lsu.sv
source/data_mem.sv
source/lsu_top.sv
bench/tb_lsu_top.sv

/* Makefile */
SRCS := $(filter %.sv,$(shell cat list.f)) source/lsu_cfg.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_lsu_top: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_top \
	  -f list.f -Mdir obj_dir

run: obj_dir/Vtb_lsu_top
	./obj_dir/Vtb_lsu_top | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_lsu_top.sv */
// Testbench for the load/store path top level.
// Runs directed byte, halfword, word and unknown-size accesses over the
// four-phase command port, then a long LFSR-driven mix. A byte shadow of
// the tested memory window predicts every load result, and a checker
// process guards the handshake order and the latency bound.

`timescale 1ns/100ps

`include "lsu_cfg.svh"

module tb_lsu_top;

  import ldst_pkg::*;

  localparam int unsigned RESET_CYCLES   = 8;
  localparam int unsigned LAT            = `MEM_WAIT_CYCLES + 3; // nominal req to ack.
  localparam int unsigned LAT_BOUND      = 2 * LAT;
  localparam int unsigned WIN_BASE       = 'h80; // byte address of the tested window.
  localparam int unsigned WIN_BYTES      = 64;
  localparam int unsigned N_DIRECTED     = 49;
  localparam int unsigned N_RANDOM       = 200;
  localparam int unsigned TIMEOUT_CYCLES =
    (N_DIRECTED + N_RANDOM) * LAT_BOUND + RESET_CYCLES + 2;

  logic                   clk_i;
  logic                   rst_i;
  logic                   req_i;
  logic                   ack_o;
  logic                   we_i;
  ldst_size_e             size_i;
  logic [`LSU_ADDR_W-1:0] addr_i;
  logic [`LSU_DATA_W-1:0] wdata_i;
  logic [`LSU_DATA_W-1:0] rdata_o;

  logic [7:0]  shadow [WIN_BYTES]; // expected memory contents with one entry per byte.
  logic [15:0] lfsr_q;
  logic        load_pending;       // the access in flight is a load.
  logic [31:0] exp_rdata;
  logic        ack_prev;
  logic        req_prev;
  int unsigned lat_cnt;
  int unsigned cycle_cnt;

  lsu_top uut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (req_i),
    .ack_o   (ack_o),
    .we_i    (we_i),
    .size_i  (size_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .rdata_o (rdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------
  // error reporting
  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("ERR time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic protocol_error(input string text);
    $display("time=%0t %s", $time, text);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // --------------------
  // random numbers
  // Fibonacci LFSR with taps 16, 14, 13 and 11 that shifts towards the msb.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // --------------------
  // shadow memory
  // The byte at the lowest address is the least significant.
  function automatic logic [31:0] predict_load(input logic [2:0] size, input int unsigned off);
    int unsigned w;
    w = off & ~32'd3;
    case (size)
      LDST_B:  predict_load = {{24{shadow[off][7]}}, shadow[off]};
      LDST_BU: predict_load = {24'h0, shadow[off]};
      LDST_H:  predict_load = {{16{shadow[off+1][7]}}, shadow[off+1], shadow[off]};
      LDST_HU: predict_load = {16'h0, shadow[off+1], shadow[off]};
      LDST_W:  predict_load = {shadow[w+3], shadow[w+2], shadow[w+1], shadow[w]};
      default: predict_load = '0; // no access takes place.
    endcase
  endfunction

  task automatic update_shadow(input logic [2:0] size, input int unsigned off,
                               input logic [31:0] data);
    case (size)
      LDST_B, LDST_BU: shadow[off] = data[7:0];
      LDST_H, LDST_HU: begin
        shadow[off]   = data[7:0];
        shadow[off+1] = data[15:8];
      end
      LDST_W: begin
        for (int i = 0; i < 4; i++) begin
          shadow[off+i] = data[8*i +: 8];
        end
      end
      default: ; // unknown sizes write nothing.
    endcase
  endtask

  // --------------------
  // one four-phase transaction with req_i held a random 0..3 cycles after ack_o.
  task automatic run_access(input logic we, input logic [2:0] size, input int unsigned off,
                            input logic [31:0] data);
    logic [31:0] bits;
    int unsigned gap;
    take_bits(2, bits);
    gap = 32'(bits[1:0]);
    @(posedge clk_i);
    we_i         <= we;
    size_i       <= ldst_size_e'(size);
    addr_i       <= WIN_BASE + off;
    wdata_i      <= data;
    load_pending <= !we;
    exp_rdata    <= predict_load(size, off);
    req_i        <= 1'b1;
    while (!ack_o) @(posedge clk_i);
    repeat (gap) @(posedge clk_i);
    req_i <= 1'b0;
    while (ack_o) @(posedge clk_i);
    if (we) begin
      update_shadow(size, off, data);
    end
  endtask

  // --------------------
  // handshake and data checker
  always @(posedge clk_i) begin
    if (rst_i) begin
      ack_prev = 1'b0;
      req_prev = 1'b0;
      lat_cnt  = 0;
    end else begin
      if (ack_o && !ack_prev) begin
        assert (req_i) else protocol_error("ack_o rose while req_i was low.");
        if (load_pending) begin
          assert (rdata_o === exp_rdata) else value_error("rdata_o", rdata_o, exp_rdata);
        end
      end
      if (!ack_o && ack_prev) begin
        assert (!req_i && !req_prev)
          else protocol_error("ack_o fell before req_i had been released.");
      end
      if (req_i && !ack_o) begin
        lat_cnt++; // cycles spent waiting for the acknowledge.
      end else begin
        lat_cnt = 0;
      end
      assert (lat_cnt <= LAT_BOUND)
        else protocol_error("ack_o did not rise within the latency bound.");
      ack_prev = ack_o;
      req_prev = req_i;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("time=%0t the run took longer than %0d cycles.", $time, TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  // --------------------
  // stimulus
  initial begin
    logic [31:0] r;
    logic [31:0] data;
    logic        we;
    logic [2:0]  size;
    int unsigned off;

    rst_i        = 1'b1;
    req_i        = 1'b0;
    we_i         = 1'b0;
    size_i       = LDST_W;
    addr_i       = '0;
    wdata_i      = '0;
    lfsr_q       = 16'd95;
    load_pending = 1'b0;
    exp_rdata    = '0;

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    assert (ack_o === 1'b0) else value_error("ack_o", 32'(ack_o), '0);
    assert (rdata_o === '0) else value_error("rdata_o", rdata_o, '0);

    // fill the window with known words so every later load is predictable.
    for (int k = 0; k < WIN_BYTES / 4; k++) begin
      take_bits(32, r);
      run_access(1'b1, LDST_W, 4 * k, r);
    end

    // word round trip.
    run_access(1'b1, LDST_W, 20, 32'hdead_beef);
    run_access(1'b0, LDST_W, 20, '0);

    // byte lanes. Only the low byte of wdata may reach the memory, and
    // each word load shows the lanes not yet written as still filled.
    run_access(1'b1, LDST_B, 8, 32'h5a5a_5a81);
    run_access(1'b0, LDST_W, 8, '0);
    run_access(1'b1, LDST_BU, 9, 32'ha5a5_a57e);
    run_access(1'b0, LDST_W, 8, '0);
    run_access(1'b1, LDST_B, 10, 32'h0000_00f0);
    run_access(1'b0, LDST_W, 8, '0);
    run_access(1'b1, LDST_B, 11, 32'hffff_ff0f);
    run_access(1'b0, LDST_W, 8, '0);
    run_access(1'b0, LDST_W, 12, '0); // neighbour word stays as filled.
    for (int lane = 0; lane < 4; lane++) begin
      run_access(1'b0, LDST_B, 8 + lane, '0);
      run_access(1'b0, LDST_BU, 8 + lane, '0);
    end

    // halfwords with the sign bit set in one half and clear in the other.
    run_access(1'b1, LDST_H, 16, 32'h1234_8001);
    run_access(1'b1, LDST_HU, 18, 32'habcd_7ffe);
    run_access(1'b0, LDST_H, 16, '0);
    run_access(1'b0, LDST_HU, 16, '0);
    run_access(1'b0, LDST_H, 18, '0);
    run_access(1'b0, LDST_HU, 18, '0);
    run_access(1'b0, LDST_W, 16, '0);

    // unknown size codes.
    run_access(1'b1, 3'd3, 24, 32'hffff_ffff);
    run_access(1'b1, 3'd6, 25, 32'hffff_ffff);
    run_access(1'b1, 3'd7, 26, 32'hffff_ffff);
    run_access(1'b0, LDST_W, 24, '0);
    run_access(1'b0, 3'd3, 24, '0);
    run_access(1'b0, 3'd6, 28, '0);
    run_access(1'b0, 3'd7, 30, '0);

    // long random mix aligned to the access size.
    for (int n = 0; n < N_RANDOM; n++) begin
      take_bits(1, r);
      we = r[0];
      take_bits(3, r);
      size = r[2:0];
      take_bits(6, r);
      off = 32'(r[5:0]);
      case (size)
        LDST_H, LDST_HU: off = off & ~32'd1;
        LDST_W:          off = off & ~32'd3;
        default:         ;
      endcase
      take_bits(32, r);
      data = r;
      run_access(we, size, off, data);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* source/lsu_top.sv */
// Top level of the load/store path.
// Connects the four-phase command port, the load/store unit and the
// data memory. One access is in flight at a time.

`timescale 1ns/100ps

`include "lsu_cfg.svh"

module lsu_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  output logic                   ack_o,
  input  logic                   we_i,
  input  ldst_pkg::ldst_size_e   size_i,
  input  logic [`LSU_ADDR_W-1:0] addr_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  import ldst_pkg::*;
  import mem_pkg::*;

  // --------------------
  // command port to lsu
  logic                   core_req;
  logic                   core_we;
  ldst_size_e             core_size;
  logic [`LSU_ADDR_W-1:0] core_addr;
  logic [`LSU_DATA_W-1:0] core_wd;
  logic [`LSU_DATA_W-1:0] core_rd;
  logic                   core_stall;

  // --------------------
  // lsu to memory
  logic                   mem_req;
  logic                   mem_we;
  byte_en_t               mem_be;
  logic [`LSU_ADDR_W-1:0] mem_addr;
  logic [`LSU_DATA_W-1:0] mem_wd;
  logic [`LSU_DATA_W-1:0] mem_rd;
  logic                   mem_ready;

  lsu_cmd_port u_cmd_port (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .ack_o        (ack_o),
    .we_i         (we_i),
    .size_i       (size_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .rdata_o      (rdata_o),
    .core_req_o   (core_req),
    .core_we_o    (core_we),
    .core_size_o  (core_size),
    .core_addr_o  (core_addr),
    .core_wd_o    (core_wd),
    .core_rd_i    (core_rd),
    .core_stall_i (core_stall)
  );

  lsu u_lsu (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .core_req_i   (core_req),
    .core_we_i    (core_we),
    .core_size_i  (core_size),
    .core_addr_i  (core_addr),
    .core_wd_i    (core_wd),
    .core_rd_o    (core_rd),
    .core_stall_o (core_stall),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_be_o     (mem_be),
    .mem_addr_o   (mem_addr),
    .mem_wd_o     (mem_wd),
    .mem_rd_i     (mem_rd),
    .mem_ready_i  (mem_ready)
  );

  data_mem u_data_mem (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mem_req_i   (mem_req),
    .mem_we_i    (mem_we),
    .mem_be_i    (mem_be),
    .mem_addr_i  (mem_addr),
    .mem_wd_i    (mem_wd),
    .mem_rd_o    (mem_rd),
    .mem_ready_o (mem_ready)
  );

endmodule

/* source/data_mem.sv */
// Byte-enabled word memory with a fixed access latency.
// A request seen in idle is answered MEM_WAIT_CYCLES later with a
// one-cycle ready pulse. Stores write the enabled bytes and loads
// present the whole word on mem_rd_o during that pulse.

`timescale 1ns/100ps

`include "lsu_cfg.svh"

module data_mem (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   mem_req_i,
  input  logic                   mem_we_i,
  input  mem_pkg::byte_en_t      mem_be_i,
  input  logic [`LSU_ADDR_W-1:0] mem_addr_i,
  input  logic [`LSU_DATA_W-1:0] mem_wd_i,
  output logic [`LSU_DATA_W-1:0] mem_rd_o,
  output logic                   mem_ready_o
);

  import mem_pkg::*;

  localparam int unsigned IDX_W  = $clog2(`MEM_DEPTH_WORDS);
  localparam int unsigned WAIT_W = $clog2(`MEM_WAIT_CYCLES + 1);

  logic [`LSU_DATA_W-1:0] mem_q [`MEM_DEPTH_WORDS];
  logic [`LSU_DATA_W-1:0] rd_q;
  logic [IDX_W-1:0]       idx;
  logic [WAIT_W-1:0]      wait_cnt;
  logic                   last_wait; // access is performed at the end of this cycle.
  mem_state_e             state_q;

  assign idx       = mem_addr_i[2 +: IDX_W]; // byte offset dropped, upper bits wrap.
  assign last_wait = (state_q == MEM_WAIT) &&
                     (wait_cnt == WAIT_W'(`MEM_WAIT_CYCLES - 1));

  // --------------------
  // state and wait counter
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= MEM_IDLE;
      wait_cnt <= '0;
    end else begin
      case (state_q)
        MEM_IDLE: begin
          if (mem_req_i) begin
            state_q  <= MEM_WAIT;
            wait_cnt <= WAIT_W'(1);
          end
        end
        MEM_WAIT: begin
          if (last_wait) begin
            state_q <= MEM_DONE;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        default: state_q <= MEM_IDLE; // MEM_DONE lasts one cycle.
      endcase
    end
  end

  // --------------------
  // storage
  always_ff @(posedge clk_i) begin
    if (last_wait) begin
      if (mem_we_i) begin
        for (int i = 0; i < MEM_LANES; i++) begin
          if (mem_be_i[i]) begin
            mem_q[idx][8*i +: 8] <= mem_wd_i[8*i +: 8];
          end
        end
      end
      rd_q <= mem_q[idx]; // old word, only used by loads.
    end
  end

  assign mem_rd_o    = rd_q;
  assign mem_ready_o = (state_q == MEM_DONE);

  // the lsu must not change the access while the memory counts.
  a_req_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    state_q == MEM_WAIT |-> mem_req_i && $stable(mem_we_i) && $stable(mem_be_i)
                            && $stable(mem_addr_i) && $stable(mem_wd_i)
  ) else $error("memory request changed during the wait.");

endmodule

/* source/lsu.sv */
// Load/store unit between the command port and the data memory.
// Turns a byte, halfword or word access into a word-aligned memory
// request with byte enables and replicated store data, stalls the
// requester until the memory is ready, and extracts and extends
// the addressed part of a loaded word.

`timescale 1ns/100ps

`include "lsu_cfg.svh"

module lsu (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // core side.
  input  logic                   core_req_i,
  input  logic                   core_we_i,
  input  ldst_pkg::ldst_size_e   core_size_i,
  input  logic [`LSU_ADDR_W-1:0] core_addr_i,
  input  logic [`LSU_DATA_W-1:0] core_wd_i,
  output logic [`LSU_DATA_W-1:0] core_rd_o,
  output logic                   core_stall_o,
  // memory side.
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output mem_pkg::byte_en_t      mem_be_o,
  output logic [`LSU_ADDR_W-1:0] mem_addr_o,
  output logic [`LSU_DATA_W-1:0] mem_wd_o,
  input  logic [`LSU_DATA_W-1:0] mem_rd_i,
  input  logic                   mem_ready_i
);

  import ldst_pkg::*;
  import mem_pkg::*;

  localparam int unsigned DW = `LSU_DATA_W;

  logic        stall_q; // previous cycle was stalled.
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // --------------------
  // stall generation
  // The first cycle of a request always stalls. Ready only ends the
  // stall once the memory has seen the request for a full cycle.
  assign core_stall_o = core_req_i && !(stall_q && mem_ready_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= core_stall_o;
    end
  end

  // request fields go straight through, address forced to a word.
  assign mem_req_o  = core_req_i;
  assign mem_we_o   = core_we_i;
  assign mem_addr_o = {core_addr_i[`LSU_ADDR_W-1:2], 2'b00};

  // --------------------
  // byte enables and store lanes
  always_comb begin
    case (core_size_i)
      LDST_B, LDST_BU: mem_be_o = byte_en_t'(1) << core_addr_i[1:0];
      LDST_H, LDST_HU: mem_be_o = core_addr_i[1] ? 4'b1100 : 4'b0011;
      LDST_W:          mem_be_o = '1;
      default:         mem_be_o = '0; // unknown size touches no byte.
    endcase
  end

  // the memory picks the lane through mem_be_o.
  always_comb begin
    case (core_size_i)
      LDST_B, LDST_BU: mem_wd_o = {MEM_LANES{core_wd_i[7:0]}};
      LDST_H, LDST_HU: mem_wd_o = {(MEM_LANES / 2){core_wd_i[15:0]}};
      LDST_W:          mem_wd_o = core_wd_i;
      default:         mem_wd_o = '0;
    endcase
  end

  // --------------------
  // load extraction
  assign ld_byte = mem_rd_i[{core_addr_i[1:0], 3'b000} +: 8];
  assign ld_half = mem_rd_i[{core_addr_i[1], 4'b0000} +: 16];

  always_comb begin
    case (core_size_i)
      LDST_B:  core_rd_o = {{(DW - 8){ld_byte[7]}}, ld_byte};
      LDST_BU: core_rd_o = {{(DW - 8){1'b0}}, ld_byte};
      LDST_H:  core_rd_o = {{(DW - 16){ld_half[15]}}, ld_half};
      LDST_HU: core_rd_o = {{(DW - 16){1'b0}}, ld_half};
      LDST_W:  core_rd_o = mem_rd_i;
      default: core_rd_o = '0; // unknown size reads zero.
    endcase
  end

  // --------------------
  // misaligned accesses are not split, the requester must avoid them.
  a_half_aligned: assert property (
    @(posedge clk_i) disable iff (rst_i)
    core_req_i && (core_size_i inside {LDST_H, LDST_HU}) |-> !core_addr_i[0]
  ) else $error("misaligned halfword access.");

  a_word_aligned: assert property (
    @(posedge clk_i) disable iff (rst_i)
    core_req_i && core_size_i == LDST_W |-> core_addr_i[1:0] == 2'b00
  ) else $error("misaligned word access.");

  // the requester holds its fields for the whole stall.
  a_be_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    core_stall_o |=> $stable(mem_be_o)
  ) else $error("mem_be_o changed during a stall.");

endmodule

/* source/lsu_cmd_port.sv */
// External command port of the load/store path.
// Takes one access over a four-phase req/ack handshake, registers it and
// holds it at the lsu until the lsu drops its stall. The load result is
// returned on rdata_o together with ack_o.

`timescale 1ns/100ps

`include "lsu_cfg.svh"

module lsu_cmd_port (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // four-phase requester side.
  input  logic                   req_i,
  output logic                   ack_o,
  input  logic                   we_i,
  input  ldst_pkg::ldst_size_e   size_i,
  input  logic [`LSU_ADDR_W-1:0] addr_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  output logic [`LSU_DATA_W-1:0] rdata_o,
  // lsu side.
  output logic                   core_req_o,
  output logic                   core_we_o,
  output ldst_pkg::ldst_size_e   core_size_o,
  output logic [`LSU_ADDR_W-1:0] core_addr_o,
  output logic [`LSU_DATA_W-1:0] core_wd_o,
  input  logic [`LSU_DATA_W-1:0] core_rd_i,
  input  logic                   core_stall_i
);

  import ldst_pkg::*;

  cmd_state_e state_q;
  logic       core_done; // the lsu completes the access in this cycle.

  assign core_done = core_req_o && !core_stall_i;

  // --------------------
  // command registers
  // The requester keeps its fields stable while req_i is high, so
  // one capture on acceptance is enough.
  always_ff @(posedge clk_i) begin
    if (state_q == CMD_IDLE && req_i) begin
      core_we_o   <= we_i;
      core_size_o <= size_i;
      core_addr_o <= addr_i;
      core_wd_o   <= wdata_i;
    end
  end

  // --------------------
  // handshake FSM
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= CMD_IDLE;
      core_req_o <= 1'b0;
      ack_o      <= 1'b0;
      rdata_o    <= '0;
    end else begin
      case (state_q)
        CMD_IDLE: begin
          if (req_i) begin
            core_req_o <= 1'b1; // request reaches the lsu next cycle.
            state_q    <= CMD_BUSY;
          end
        end
        CMD_BUSY: begin
          if (core_done) begin
            if (!core_we_o) begin
              rdata_o <= core_rd_i; // load data is valid only in this cycle.
            end
            core_req_o <= 1'b0;
            ack_o      <= 1'b1;
            state_q    <= CMD_DONE;
          end
        end
        CMD_DONE: begin
          // a slow release of req_i simply keeps ack_o up.
          if (!req_i) begin
            ack_o   <= 1'b0;
            state_q <= CMD_IDLE;
          end
        end
        default: begin
          core_req_o <= 1'b0;
          ack_o      <= 1'b0;
          state_q    <= CMD_IDLE;
        end
      endcase
    end
  end

  // --------------------
  // a new access to the lsu only starts once the previous
  // handshake has fully closed.
  a_no_req_during_ack: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $rose(core_req_o) |-> !ack_o
  ) else $error("core_req_o rose while ack_o was high.");

endmodule

/* source/mem_pkg.sv */
// Memory-bus definitions for the load/store path.
// Shared by the lsu, which forms the byte enables, and the data memory.

package mem_pkg;

  // one enable bit per byte lane of a word.
  localparam int unsigned MEM_LANES = 4;

  typedef logic [MEM_LANES-1:0] byte_en_t;

  // states of the data memory.
  typedef enum logic [1:0] {
    MEM_IDLE, // waiting for mem_req.
    MEM_WAIT, // counting wait cycles.
    MEM_DONE  // ready pulse, request ignored.
  } mem_state_e;

endpackage

/* source/ldst_pkg.sv */
// Core-side definitions for the load/store path.
// Holds the access size code and the states of the external command port.
// Import it in the module body; use scoped names in port lists.

package ldst_pkg;

  // size and sign of one access, coded like the RISC-V funct3 field.
  // codes 3, 6 and 7 are unknown and perform no access.
  typedef enum logic [2:0] {
    LDST_B  = 3'd0, // signed byte.
    LDST_H  = 3'd1, // signed halfword.
    LDST_W  = 3'd2, // word.
    LDST_BU = 3'd4, // unsigned byte.
    LDST_HU = 3'd5  // unsigned halfword.
  } ldst_size_e;

  // states of the four-phase command port.
  typedef enum logic [1:0] {
    CMD_IDLE, // waiting for req_i.
    CMD_BUSY, // access in flight at the lsu.
    CMD_DONE  // ack_o high until req_i drops.
  } cmd_state_e;

endpackage

/* source/lsu_cfg.svh */
// Build-wide sizes for the load/store path.
// Include this wherever a data, address or memory dimension is needed.
// The memory model assumes at least two wait cycles.

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// --------------------
// datapath widths
`define LSU_DATA_W 32 // word width, four byte lanes.
`define LSU_ADDR_W 32 // byte address width.

// --------------------
// data memory
`define MEM_DEPTH_WORDS 256 // words in the memory, addresses wrap beyond this.
`define MEM_WAIT_CYCLES 3   // cycles from request seen to ready.

`endif
